// ==== src/board_cfg_pkg.sv ====
`default_nettype none

package board_cfg_pkg;

  // ----------------------------------------------------------
  // JAMMA joystick bus
  // ----------------------------------------------------------
  localparam int joy_w       = 8;  // One player word on the shared bus
  localparam int board_joy_w = 6;  // On-board joystick, no start/coin bits

  // Released level, inputs are active low
  localparam logic [joy_w-1:0] joy_idle = '1;

  // ----------------------------------------------------------
  // Keyboard service switches and scan doubler
  // ----------------------------------------------------------
  localparam int sw_w       = 8;
  localparam int cfg_w      = 2;   // Scan-doubler control bits
  localparam int cfg_addr_w = 21;

  // SRAM word that holds the scan-doubler register
  localparam logic [cfg_addr_w-1:0] cfg_addr = 21'h008FD5;

  // ----------------------------------------------------------
  // Audio
  // ----------------------------------------------------------
  localparam int audio_slot_log2 = 8;  // 256 cycles per channel slot

endpackage

`default_nettype wire

// ==== src/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

  // Start, 8 data, odd parity, stop
  localparam int frame_w = 11;

  // ----------------------------------------------------------
  // Prefix bytes of scan code set 2
  // ----------------------------------------------------------
  localparam logic [7:0] code_break = 8'hF0;  // Key release follows
  localparam logic [7:0] code_ext   = 8'hE0;  // Extended key follows

  // ----------------------------------------------------------
  // Keys used by the control block
  // ----------------------------------------------------------
  localparam logic [7:0] code_ctrl = 8'h14;  // Left, or right with E0
  localparam logic [7:0] code_alt  = 8'h11;
  localparam logic [7:0] code_del  = 8'h71;
  localparam logic [7:0] code_bksp = 8'h66;

  // Function keys, note the irregular set 2 layout
  localparam logic [7:0] code_f1 = 8'h05;
  localparam logic [7:0] code_f2 = 8'h06;
  localparam logic [7:0] code_f3 = 8'h04;
  localparam logic [7:0] code_f4 = 8'h0C;
  localparam logic [7:0] code_f5 = 8'h03;
  localparam logic [7:0] code_f6 = 8'h0B;
  localparam logic [7:0] code_f7 = 8'h83;
  localparam logic [7:0] code_f8 = 8'h0A;

endpackage

`default_nettype wire

// ==== src/key_event_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded key events, one strobe per data byte
interface key_event_if;

  logic       valid;     // Single-cycle strobe
  logic [7:0] code;      // Scan code without prefixes
  logic       released;  // Break prefix seen before this code
  logic       extended;  // E0 prefix seen before this code

  // Receiver side
  modport tx (
    output valid,
    output code,
    output released,
    output extended
  );

  // Consumer side, no back-pressure
  modport rx (
    input valid,
    input code,
    input released,
    input extended
  );

endinterface

`default_nettype wire

// ==== src/ps2_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver (
  input  logic    pclk,
  input  logic    arst_n,
  input  logic    ps2_clk,
  input  logic    ps2_data,
  key_event_if.tx key
);

  logic [1:0]                         clk_sync;
  logic [1:0]                         data_sync;
  logic                               clk_prev;
  logic                               fall;
  logic [ps2_pkg::frame_w-1:0]        frame;
  logic [ps2_pkg::frame_w-1:0]        frame_next;
  logic [$clog2(ps2_pkg::frame_w)-1:0] bit_cnt;
  logic                               frame_end;
  logic                               frame_ok;
  logic [7:0]                         data_byte;
  logic                               rel_pend;
  logic                               ext_pend;

  // ----------------------------------------------------------
  // Line synchronizers, idle high on both lines
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign fall = clk_prev & ~clk_sync[1];

  // LSB first, so the start bit ends up in bit 0
  assign frame_next = {data_sync[1], frame[ps2_pkg::frame_w-1:1]};
  assign frame_end  = fall && (bit_cnt == ps2_pkg::frame_w - 1);
  assign data_byte  = frame_next[8:1];

  // Start low, stop high, odd parity over data and parity bit
  assign frame_ok = ~frame_next[0] & frame_next[ps2_pkg::frame_w-1] & (^frame_next[9:1]);

  always_ff @(posedge pclk) begin
    if (fall) frame <= frame_next;
  end

  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (frame_end) begin
      bit_cnt <= '0;
    end else if (fall) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Prefix tracking and event strobe
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      key.valid <= 1'b0;
      rel_pend  <= 1'b0;
      ext_pend  <= 1'b0;
    end else begin
      key.valid <= 1'b0;
      if (frame_end && frame_ok) begin
        if (data_byte == ps2_pkg::code_break) begin
          rel_pend <= 1'b1;
        end else if (data_byte == ps2_pkg::code_ext) begin
          ext_pend <= 1'b1;
        end else begin
          key.valid <= 1'b1;  // Data byte consumes the pending flags
          rel_pend  <= 1'b0;
          ext_pend  <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (frame_end && frame_ok) begin
      key.code     <= data_byte;
      key.released <= rel_pend;
      key.extended <= ext_pend;
    end
  end

endmodule

`default_nettype wire

// ==== src/board_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_ctrl (
  input  logic                           pclk,
  input  logic                           arst_n,
  key_event_if.rx                        key,
  input  logic [board_cfg_pkg::cfg_w-1:0] cfg_dq,
  output logic                           core_reset,
  output logic                           reboot,
  output logic [board_cfg_pkg::sw_w-1:0]  scan_sw,
  output logic [board_cfg_pkg::cfg_w-1:0] scandbl_ctrl
);

  logic                          ctrl_held;
  logic                          alt_held;
  logic                          press;
  logic                          chord;
  logic [board_cfg_pkg::sw_w-1:0] toggle_mask;

  assign press = key.valid & ~key.released;
  assign chord = ctrl_held & alt_held;

  // ----------------------------------------------------------
  // Function key to switch bit
  // ----------------------------------------------------------
  always_comb begin
    toggle_mask = '0;
    if (!key.extended) begin  // F keys never carry E0
      case (key.code)
        ps2_pkg::code_f1: toggle_mask[0] = 1'b1;
        ps2_pkg::code_f2: toggle_mask[1] = 1'b1;
        ps2_pkg::code_f3: toggle_mask[2] = 1'b1;
        ps2_pkg::code_f4: toggle_mask[3] = 1'b1;
        ps2_pkg::code_f5: toggle_mask[4] = 1'b1;
        ps2_pkg::code_f6: toggle_mask[5] = 1'b1;
        ps2_pkg::code_f7: toggle_mask[6] = 1'b1;
        ps2_pkg::code_f8: toggle_mask[7] = 1'b1;
        default:          toggle_mask    = '0;
      endcase
    end
  end

  // Modifier state, left and right keys share the code
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_held <= 1'b0;
      alt_held  <= 1'b0;
    end else if (key.valid) begin
      if (key.code == ps2_pkg::code_ctrl) ctrl_held <= ~key.released;
      if (key.code == ps2_pkg::code_alt)  alt_held  <= ~key.released;
    end
  end

  // ----------------------------------------------------------
  // Chord pulses, switches and config register
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      core_reset   <= 1'b0;
      reboot       <= 1'b0;
      scan_sw      <= '0;
      scandbl_ctrl <= '0;
    end else begin
      core_reset   <= press & chord & (key.code == ps2_pkg::code_del);
      reboot       <= press & chord & (key.code == ps2_pkg::code_bksp);
      scandbl_ctrl <= cfg_dq;
      if (press) scan_sw <= scan_sw ^ toggle_mask;  // Releases leave it alone
    end
  end

endmodule

`default_nettype wire

// ==== src/joy_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module joy_mux (
  input  logic                                 pclk,
  input  logic                                 arst_n,
  input  logic [board_cfg_pkg::joy_w-1:0]       jamma_joy,
  input  logic [board_cfg_pkg::board_joy_w-1:0] board_joy,
  output logic                                 joy_select,
  output logic [board_cfg_pkg::joy_w-1:0]       joystick1,
  output logic [board_cfg_pkg::joy_w-1:0]       joystick2
);

  logic [board_cfg_pkg::joy_w-1:0] board_mask;

  // Start and coin bits come from the JAMMA bus only
  assign board_mask = {{(board_cfg_pkg::joy_w - board_cfg_pkg::board_joy_w){1'b1}}, board_joy};

  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      joy_select <= 1'b0;
    end else begin
      joy_select <= ~joy_select;  // Player select flips every cycle
    end
  end

  // ----------------------------------------------------------
  // Capture on opposite phases of the select line
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      joystick1 <= board_cfg_pkg::joy_idle;
      joystick2 <= board_cfg_pkg::joy_idle;
    end else if (!joy_select) begin
      joystick1 <= jamma_joy & board_mask;  // Active low, AND merges both sticks
    end else begin
      joystick2 <= jamma_joy;
    end
  end

endmodule

`default_nettype wire

// ==== src/audio_alt.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_alt (
  input  logic pclk,
  input  logic arst_n,
  input  logic audio_l,
  input  logic audio_r,
  output logic audio_mono
);

  // Top bit picks the channel, lower bits time the slot
  logic [board_cfg_pkg::audio_slot_log2:0] slot_cnt;

  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      slot_cnt   <= '0;
      audio_mono <= 1'b0;
    end else begin
      slot_cnt <= slot_cnt + 1'b1;
      if (slot_cnt[board_cfg_pkg::audio_slot_log2]) begin
        audio_mono <= audio_r;
      end else begin
        audio_mono <= audio_l;  // Left channel in the first slot
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/arcade_board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module arcade_board_top (
  input  logic                                 pclk,
  input  logic                                 arst_n,
  input  logic                                 ps2_clk,
  input  logic                                 ps2_data,
  input  logic [board_cfg_pkg::joy_w-1:0]       jamma_joy,
  input  logic [board_cfg_pkg::board_joy_w-1:0] board_joy,
  input  logic [board_cfg_pkg::cfg_w-1:0]       cfg_dq,
  input  logic                                 audio_l,
  input  logic                                 audio_r,
  output logic                                 joy_select,
  output logic [board_cfg_pkg::joy_w-1:0]       joystick1,
  output logic [board_cfg_pkg::joy_w-1:0]       joystick2,
  output logic                                 core_reset,
  output logic                                 reboot,
  output logic [board_cfg_pkg::sw_w-1:0]        scan_sw,
  output logic [board_cfg_pkg::cfg_w-1:0]       scandbl_ctrl,
  output logic [board_cfg_pkg::cfg_addr_w-1:0]  cfg_addr,
  output logic                                 audio_mono,
  output logic                                 led
);

  key_event_if key_bus ();

  // ----------------------------------------------------------
  // Keyboard path
  // ----------------------------------------------------------
  ps2_receiver ps2_receiver_i (
    .pclk     (pclk),
    .arst_n   (arst_n),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .key      (key_bus)
  );

  board_ctrl board_ctrl_i (
    .pclk         (pclk),
    .arst_n       (arst_n),
    .key          (key_bus),
    .cfg_dq       (cfg_dq),
    .core_reset   (core_reset),
    .reboot       (reboot),
    .scan_sw      (scan_sw),
    .scandbl_ctrl (scandbl_ctrl)
  );

  // ----------------------------------------------------------
  // JAMMA joysticks and audio
  // ----------------------------------------------------------
  joy_mux joy_mux_i (
    .pclk       (pclk),
    .arst_n     (arst_n),
    .jamma_joy  (jamma_joy),
    .board_joy  (board_joy),
    .joy_select (joy_select),
    .joystick1  (joystick1),
    .joystick2  (joystick2)
  );

  audio_alt audio_alt_i (
    .pclk       (pclk),
    .arst_n     (arst_n),
    .audio_l    (audio_l),
    .audio_r    (audio_r),
    .audio_mono (audio_mono)
  );

  assign cfg_addr = board_cfg_pkg::cfg_addr;  // Fixed scan-doubler location
  assign led      = scan_sw[0];

endmodule

`default_nettype wire

// ==== tests/arcade_board_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module arcade_board_properties (
  input logic pclk,
  input logic arst_n,
  input logic core_reset,
  input logic reboot,
  input logic joy_select,
  input logic audio_l,
  input logic audio_r,
  input logic audio_mono
);

  localparam int slot_msb = board_cfg_pkg::audio_slot_log2;

  logic [slot_msb:0] slot_cnt;  // Tracks the channel slot from reset
  logic              sel;
  logic              sel_q;

  assign sel = slot_cnt[slot_msb] ? audio_r : audio_l;

  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      slot_cnt <= '0;
      sel_q    <= 1'b0;
    end else begin
      slot_cnt <= slot_cnt + 1'b1;
      sel_q    <= sel;
    end
  end

  // ----------------------------------------------------------
  // Single-cycle pulses
  // ----------------------------------------------------------
  reset_one_cycle: assert property (@(posedge pclk) disable iff (!arst_n)
    core_reset |=> !core_reset)
    else $error("core_reset high for two cycles in a row");

  reboot_one_cycle: assert property (@(posedge pclk) disable iff (!arst_n)
    reboot |=> !reboot)
    else $error("reboot high for two cycles in a row");

  // ----------------------------------------------------------
  // Joystick select and audio pin
  // ----------------------------------------------------------
  select_toggles: assert property (@(posedge pclk) disable iff (!arst_n)
    $past(arst_n) |-> (joy_select != $past(joy_select)))
    else $error("joy_select did not alternate");

  // A new pin value needs a new selected input one cycle before
  audio_change: assert property (@(posedge pclk) disable iff (!arst_n)
    (audio_mono != $past(audio_mono)) |-> $past(sel != sel_q))
    else $error("audio_mono changed without a slot boundary or input change");

endmodule

bind arcade_board_top arcade_board_properties props_i (
  .pclk       (pclk),
  .arst_n     (arst_n),
  .core_reset (core_reset),
  .reboot     (reboot),
  .joy_select (joy_select),
  .audio_l    (audio_l),
  .audio_r    (audio_r),
  .audio_mono (audio_mono)
);

`default_nettype wire

// ==== tests/tb_arcade_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_board;

  localparam string data_path  = "tests/arcade_testdata.txt";
  localparam int    half_bit   = 8;  // PS/2 half period in pclk cycles
  localparam int    sync_lat   = 2;  // DUT line synchronizer depth
  localparam int    pulse_wait = 4;

  logic                                 pclk;
  logic                                 arst_n;
  logic                                 ps2_clk;
  logic                                 ps2_data;
  logic [board_cfg_pkg::joy_w-1:0]       jamma_joy;
  logic [board_cfg_pkg::board_joy_w-1:0] board_joy;
  logic [board_cfg_pkg::cfg_w-1:0]       cfg_dq;
  logic                                 audio_l;
  logic                                 audio_r;
  logic                                 joy_select;
  logic [board_cfg_pkg::joy_w-1:0]       joystick1;
  logic [board_cfg_pkg::joy_w-1:0]       joystick2;
  logic                                 core_reset;
  logic                                 reboot;
  logic [board_cfg_pkg::sw_w-1:0]        scan_sw;
  logic [board_cfg_pkg::cfg_w-1:0]       scandbl_ctrl;
  logic [board_cfg_pkg::cfg_addr_w-1:0]  cfg_addr;
  logic                                 audio_mono;
  logic                                 led;

  int cyc       = 0;
  int since_rst = 0;  // Cycles counted since reset release
  int cyc_limit = 0;
  int stop_cyc  = 0;  // Cycle of the last stop bit clock edge
  int rst_cnt   = 0;
  int rbt_cnt   = 0;
  int rst_cyc   = 0;
  int rbt_cyc   = 0;
  int rst_base  = 0;
  int rbt_base  = 0;

  arcade_board_top dut_i (.*);

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  // ----------------------------------------------------------
  // Cycle count, pulse monitor and timeout
  // ----------------------------------------------------------
  always @(posedge pclk) begin
    cyc <= cyc + 1;
    if (arst_n) since_rst <= since_rst + 1;
    if (core_reset) begin
      rst_cnt <= rst_cnt + 1;
      rst_cyc <= cyc;
    end
    if (reboot) begin
      rbt_cnt <= rbt_cnt + 1;
      rbt_cyc <= cyc;
    end
    if (cyc_limit > 0 && cyc >= cyc_limit) begin
      fail_plain($sformatf("timeout, run exceeded %0d cycles", cyc_limit));
    end
  end

  task automatic stop_run();
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic fail_plain(input string text);
    $display("error at %0t: %s", $time, text);
    stop_run();
  endtask

  task automatic check_sw(input logic [board_cfg_pkg::sw_w-1:0] got,
                          input logic [board_cfg_pkg::sw_w-1:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_joy(input logic [board_cfg_pkg::joy_w-1:0] got,
                           input logic [board_cfg_pkg::joy_w-1:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_cfg(input logic [board_cfg_pkg::cfg_w-1:0] got,
                           input logic [board_cfg_pkg::cfg_w-1:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input logic [board_cfg_pkg::cfg_addr_w-1:0] got,
                            input logic [board_cfg_pkg::cfg_addr_w-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // ----------------------------------------------------------
  // PS/2 device side
  // ----------------------------------------------------------
  task automatic send_frame(input logic [7:0] data, input logic bad_par);
    logic [10:0] frame;
    int          i;
    frame = {1'b1, (~(^data)) ^ bad_par, data, 1'b0};  // Stop, odd parity, data, start
    @(posedge pclk);
    for (i = 0; i < 11; i++) begin
      ps2_data <= frame[i];
      repeat (half_bit) @(posedge pclk);
      ps2_clk  <= 1'b0;
      stop_cyc = cyc;
      repeat (half_bit) @(posedge pclk);
      ps2_clk  <= 1'b1;
    end
    repeat (half_bit) @(posedge pclk);
  endtask

  task automatic send_bytes(input logic [31:0] bytes, input logic bad_par);
    int k;
    for (k = 3; k >= 0; k--) begin
      if (bytes[8*k +: 8] != 8'h00) send_frame(bytes[8*k +: 8], bad_par);
    end
  endtask

  function automatic int pulse_count(input bit is_rbt);
    return is_rbt ? rbt_cnt : rst_cnt;
  endfunction

  task automatic expect_pulse(input bit is_rbt, input logic exp);
    string name;
    int    base;
    int    last;
    name = is_rbt ? "reboot" : "core_reset";
    base = is_rbt ? rbt_base : rst_base;
    while (pulse_count(is_rbt) == base && cyc < stop_cyc + sync_lat + pulse_wait) begin
      @(negedge pclk);
    end
    last = is_rbt ? rbt_cyc : rst_cyc;
    if (exp && (pulse_count(is_rbt) == base || last > stop_cyc + sync_lat + pulse_wait)) begin
      fail_plain($sformatf("%s pulse did not arrive within %0d cycles of the stop bit",
                           name, pulse_wait));
    end
    if (pulse_count(is_rbt) - base > 1) fail_plain({name, " pulsed more than once"});
    check_bit(pulse_count(is_rbt) != base, exp, {name, " pulse"});
    if (is_rbt) rbt_base = rbt_cnt;
    else rst_base = rst_cnt;
  endtask

  // ----------------------------------------------------------
  // Scan-doubler register, joystick and audio checks
  // ----------------------------------------------------------
  task automatic sweep_cfg();
    logic [board_cfg_pkg::cfg_w-1:0] prev;
    logic [board_cfg_pkg::cfg_w-1:0] val;
    int                              i;
    prev = cfg_dq;
    for (i = 0; i < 4; i++) begin
      val = prev + 1'b1;
      @(posedge pclk);
      cfg_dq <= val;
      @(negedge pclk);
      check_cfg(scandbl_ctrl, prev, "scandbl_ctrl before its delay");
      @(negedge pclk);
      check_cfg(scandbl_ctrl, val, "scandbl_ctrl");
      prev = val;
    end
  endtask

  task automatic run_joy(input int rounds);
    logic [board_cfg_pkg::joy_w-1:0]       j;
    logic [board_cfg_pkg::board_joy_w-1:0] b;
    logic [board_cfg_pkg::joy_w-1:0]       merged;
    repeat (rounds) begin
      j = $urandom;
      b = $urandom;
      @(posedge pclk);
      jamma_joy <= j;
      board_joy <= b;
      repeat (4) @(posedge pclk);
      @(negedge pclk);
      // Directions merge active low while start and coin bits pass
      merged = {j[board_cfg_pkg::joy_w-1:board_cfg_pkg::board_joy_w],
                j[board_cfg_pkg::board_joy_w-1:0] & b};
      check_joy(joystick1, merged, "joystick1");
      check_joy(joystick2, j, "joystick2");
      check_bit(joy_select, since_rst[0], "joy_select");  // Low at reset, flips each cycle
    end
  endtask

  task automatic run_audio(input logic [1:0] lr);
    int slot;
    slot = 1 << board_cfg_pkg::audio_slot_log2;
    @(posedge pclk);
    audio_l <= lr[1];
    audio_r <= lr[0];
    do @(negedge pclk); while (since_rst % (2 * slot) != slot / 2);
    check_bit(audio_mono, lr[1], "audio_mono in left slot");
    do @(negedge pclk); while (since_rst % (2 * slot) != slot + slot / 2);
    check_bit(audio_mono, lr[0], "audio_mono in right slot");
  endtask

  // ----------------------------------------------------------
  // Command sequencer
  // ----------------------------------------------------------
  initial begin
    string line;
    string cmd;
    int    fd;
    int    arg;
    int    n_lines;
    arst_n    = 1'b0;
    ps2_clk   = 1'b1;
    ps2_data  = 1'b1;
    jamma_joy = board_cfg_pkg::joy_idle;
    board_joy = '1;
    cfg_dq    = '0;
    audio_l   = 1'b0;
    audio_r   = 1'b0;
    n_lines   = 0;
    void'($urandom(32'h7f3f_caed));
    fd = $fopen(data_path, "r");
    if (fd == 0) fail_plain({"cannot open ", data_path});
    while ($fgets(line, fd)) n_lines++;
    $fclose(fd);
    cyc_limit = n_lines * 300 + 2000;

    repeat (8) @(posedge pclk);
    arst_n <= 1'b1;
    @(negedge pclk);
    check_joy(joystick1, board_cfg_pkg::joy_idle, "joystick1 after reset");
    check_joy(joystick2, board_cfg_pkg::joy_idle, "joystick2 after reset");
    check_sw(scan_sw, '0, "scan_sw after reset");
    check_addr(cfg_addr, board_cfg_pkg::cfg_addr, "cfg_addr");
    sweep_cfg();

    fd = $fopen(data_path, "r");
    while ($fgets(line, fd)) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      if ($sscanf(line, "%s %h", cmd, arg) != 2) fail_plain({"bad command line: ", line});
      case (cmd)
        "key": send_bytes(arg, 1'b0);
        "bad": send_bytes(arg, 1'b1);  // Same bytes with parity flipped
        "rst": expect_pulse(1'b0, arg[0]);
        "rbt": expect_pulse(1'b1, arg[0]);
        "joy": run_joy(arg);
        "aud": run_audio(arg[1:0]);
        "sw": begin
          @(negedge pclk);
          check_sw(scan_sw, arg[board_cfg_pkg::sw_w-1:0], "scan_sw");
          check_bit(led, arg[0], "led");
        end
        default: fail_plain({"unknown command ", cmd});
      endcase
    end
    $fclose(fd);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
src/board_cfg_pkg.sv
src/ps2_pkg.sv
src/key_event_if.sv
src/ps2_receiver.sv
src/board_ctrl.sv
src/joy_mux.sv
src/audio_alt.sv
src/arcade_board_top.sv
tests/arcade_board_properties.sv
tests/tb_arcade_board.sv

// ==== tests/arcade_testdata.txt ====
# Columns: command, hex argument. key/bad send PS/2 bytes high byte first, 00 skipped
# sw = scan_sw, rst/rbt = pulse (1) or none (0), joy = random rounds, aud = {left, right}
aud 2
key 05f005
key 04f004
key 05f005
sw 04
key 1411
key 71
rst 1
key f071f014
key 71
rst 0
key f071f011
key 141166
rbt 1
key f066f011
key 66
rbt 0
key f066
key 11
bad 71
rst 0
bad 05
sw 04
key f011f014
rbt 0
joy 10
sw 04
